// File: sd_proto_pkg.sv
`default_nettype none

package sd_proto_pkg;

  // Command word as presented by the host, start and transmission bits included
  localparam int CMD_W = 40;

  // Longest response (R2) including start bit
  localparam int RSP_W = 136;

  localparam int CRC7_W = 7;

  // Length inputs and bit counters
  localparam int LEN_W = 8;

  // Taps of x^7 + x^3 + 1, x^7 term implied by the shift
  localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

  typedef logic [CMD_W-1:0]  cmd_word_t;
  typedef logic [RSP_W-1:0]  rsp_word_t;
  typedef logic [CRC7_W-1:0] crc7_t;
  typedef logic [LEN_W-1:0]  bit_len_t;

endpackage

`default_nettype wire

// File: sd_cmd_state_pkg.sv
`default_nettype none

package sd_cmd_state_pkg;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_SEND,
    CTRL_RECEIVE,
    CTRL_DONE
  } ctrl_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_CMD,
    TX_CRC,
    TX_END
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_WAIT_START,
    RX_DATA,
    RX_CRC,
    RX_CHECK
  } rx_state_t;

endpackage

`default_nettype wire

// File: sd_cmd_tx_if.sv
`default_nettype none

interface sd_cmd_tx_if;
  import sd_proto_pkg::*;

  // Single-cycle kick, cmd and cmd_len are sampled with it
  logic      start;
  cmd_word_t cmd;
  bit_len_t  cmd_len;

  // High while the end bit is on the line
  logic      done;

  modport ctrl (
    output start,
    output cmd,
    output cmd_len,
    input  done
  );

  modport engine (
    input  start,
    input  cmd,
    input  cmd_len,
    output done
  );

endinterface

`default_nettype wire

// File: sd_rsp_rx_if.sv
`default_nettype none

interface sd_rsp_rx_if;
  import sd_proto_pkg::*;

  logic      start;

  // Response length in bits, start bit counted
  bit_len_t  rsp_len;

  // Result, valid from done until the next start
  logic      done;
  rsp_word_t rsp;
  logic      crc_err;

  modport ctrl (
    output start,
    output rsp_len,
    input  done,
    input  rsp,
    input  crc_err
  );

  modport engine (
    input  start,
    input  rsp_len,
    output done,
    output rsp,
    output crc_err
  );

endinterface

`default_nettype wire

// File: sd_crc7.sv
`default_nettype none

module sd_crc7 (
  input  logic                i_sd_clk,
  input  logic                rst,
  input  logic                i_clr,
  input  logic                i_en,
  input  logic                i_bit,
  output sd_proto_pkg::crc7_t o_crc
);
  import sd_proto_pkg::*;

  logic fb;

  // Incoming bit against the outgoing MSB
  assign fb = i_bit ^ o_crc[CRC7_W-1];

  always_ff @(posedge i_sd_clk) begin
    if (rst || i_clr) begin
      o_crc <= '0;
    end
    else if (i_en) begin
      o_crc <= {o_crc[CRC7_W-2:0], 1'b0} ^ (fb ? CRC7_POLY : '0);
    end
  end

endmodule

`default_nettype wire

// File: sd_cmd_tx.sv
`default_nettype none

module sd_cmd_tx (
  input  logic        i_sd_clk,
  input  logic        rst,
  input  logic        i_abort,
  sd_cmd_tx_if.engine tx,
  output logic        o_sd_cmd
);
  import sd_proto_pkg::*;
  import sd_cmd_state_pkg::*;

  tx_state_t state;
  cmd_word_t shreg;
  bit_len_t  cnt;
  bit_len_t  len_r;
  crc7_t     crc;
  logic      crc_en;
  logic      crc_bit;

  // Each command bit is folded in the same edge that puts it on the line
  assign crc_en  = !i_abort && (((state == TX_IDLE) && tx.start) ||
                                ((state == TX_CMD) && (cnt < len_r)));
  assign crc_bit = (state == TX_IDLE) ? tx.cmd[CMD_W-1] : shreg[CMD_W-1];

  assign tx.done = (state == TX_END);

  sd_crc7 u_crc (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clr    (i_abort || (state == TX_END)),
    .i_en     (crc_en),
    .i_bit    (crc_bit),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state    <= TX_IDLE;
      cnt      <= '0;
      o_sd_cmd <= 1'b1;
    end
    else if (i_abort) begin
      state    <= TX_IDLE;
      o_sd_cmd <= 1'b1;
    end
    else begin
      case (state)
        TX_IDLE: begin
          o_sd_cmd <= 1'b1;
          if (tx.start) begin
            o_sd_cmd <= tx.cmd[CMD_W-1];
            shreg    <= {tx.cmd[CMD_W-2:0], 1'b0};
            len_r    <= tx.cmd_len;
            cnt      <= LEN_W'(1);
            state    <= TX_CMD;
          end
        end
        TX_CMD: begin
          if (cnt < len_r) begin
            o_sd_cmd <= shreg[CMD_W-1];
            shreg    <= {shreg[CMD_W-2:0], 1'b0};
            cnt      <= cnt + 1'b1;
          end
          else begin
            // Last command bit already folded, CRC reuses the shifter
            o_sd_cmd <= crc[CRC7_W-1];
            shreg    <= {crc[CRC7_W-2:0], {(CMD_W-CRC7_W+1){1'b0}}};
            cnt      <= LEN_W'(1);
            state    <= TX_CRC;
          end
        end
        TX_CRC: begin
          if (cnt < CRC7_W) begin
            o_sd_cmd <= shreg[CMD_W-1];
            shreg    <= {shreg[CMD_W-2:0], 1'b0};
            cnt      <= cnt + 1'b1;
          end
          else begin
            o_sd_cmd <= 1'b1;
            state    <= TX_END;
          end
        end
        TX_END: begin
          o_sd_cmd <= 1'b1;
          state    <= TX_IDLE;
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sd_rsp_rx.sv
`default_nettype none

module sd_rsp_rx (
  input  logic        i_sd_clk,
  input  logic        rst,
  input  logic        i_abort,
  sd_rsp_rx_if.engine rx,
  input  logic        i_sd_cmd
);
  import sd_proto_pkg::*;
  import sd_cmd_state_pkg::*;

  rx_state_t state;
  bit_len_t  cnt;
  bit_len_t  len_r;
  crc7_t     crc;
  crc7_t     crc_rx;
  logic      crc_en;

  // Start bit and every payload bit go through the CRC
  assign crc_en = !i_abort && (((state == RX_WAIT_START) && !i_sd_cmd) ||
                               (state == RX_DATA));

  sd_crc7 u_crc (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clr    (i_abort || ((state == RX_IDLE) && rx.start)),
    .i_en     (crc_en),
    .i_bit    (i_sd_cmd),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state      <= RX_IDLE;
      cnt        <= '0;
      rx.done    <= 1'b0;
      rx.rsp     <= '0;
      rx.crc_err <= 1'b0;
    end
    else begin
      rx.done <= 1'b0;
      if (i_abort) begin
        state <= RX_IDLE;
      end
      else begin
        case (state)
          RX_IDLE: begin
            if (rx.start) begin
              rx.rsp     <= '0;
              rx.crc_err <= 1'b0;
              len_r      <= rx.rsp_len;
              state      <= RX_WAIT_START;
            end
          end
          RX_WAIT_START: begin
            // The zero start bit is response bit one
            if (!i_sd_cmd) begin
              rx.rsp <= {rx.rsp[RSP_W-2:0], i_sd_cmd};
              if (len_r > LEN_W'(1)) begin
                cnt   <= LEN_W'(1);
                state <= RX_DATA;
              end
              else begin
                cnt   <= '0;
                state <= RX_CRC;
              end
            end
          end
          RX_DATA: begin
            rx.rsp <= {rx.rsp[RSP_W-2:0], i_sd_cmd};
            if (cnt == len_r - 1'b1) begin
              cnt   <= '0;
              state <= RX_CRC;
            end
            else begin
              cnt <= cnt + 1'b1;
            end
          end
          RX_CRC: begin
            crc_rx <= {crc_rx[CRC7_W-2:0], i_sd_cmd};
            if (cnt == CRC7_W - 1) begin
              state <= RX_CHECK;
            end
            else begin
              cnt <= cnt + 1'b1;
            end
          end
          RX_CHECK: begin
            rx.crc_err <= (crc_rx != crc);
            rx.done    <= 1'b1;
            state      <= RX_IDLE;
          end
          default: begin
            state <= RX_IDLE;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: sd_cmd_ctrl.sv
`default_nettype none

module sd_cmd_ctrl (
  input  logic                    i_sd_clk,
  input  logic                    rst,
  input  logic                    i_cmd_en,
  input  sd_proto_pkg::cmd_word_t i_cmd,
  input  sd_proto_pkg::bit_len_t  i_cmd_len,
  input  sd_proto_pkg::bit_len_t  i_rsp_len,
  sd_cmd_tx_if.ctrl               tx,
  sd_rsp_rx_if.ctrl               rx,
  output logic                    o_abort,
  output logic                    o_sd_cmd_dir,
  output logic                    o_rsp_finished_en
);
  import sd_cmd_state_pkg::*;

  ctrl_state_t state;

  // Dropping the enable cancels whatever is in flight
  assign o_abort = !i_cmd_en;

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state             <= CTRL_IDLE;
      tx.start          <= 1'b0;
      rx.start          <= 1'b0;
      o_sd_cmd_dir      <= 1'b1;
      o_rsp_finished_en <= 1'b0;
    end
    else begin
      tx.start <= 1'b0;
      rx.start <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          o_sd_cmd_dir      <= 1'b1;
          o_rsp_finished_en <= 1'b0;
          if (i_cmd_en) begin
            tx.cmd     <= i_cmd;
            tx.cmd_len <= i_cmd_len;
            rx.rsp_len <= i_rsp_len;
            tx.start   <= 1'b1;
            state      <= CTRL_SEND;
          end
        end
        CTRL_SEND: begin
          // Turn the line around once the end bit is out
          if (tx.done) begin
            o_sd_cmd_dir <= 1'b0;
            rx.start     <= 1'b1;
            state        <= CTRL_RECEIVE;
          end
        end
        CTRL_RECEIVE: begin
          if (rx.done) begin
            o_sd_cmd_dir      <= 1'b1;
            o_rsp_finished_en <= 1'b1;
            state             <= CTRL_DONE;
          end
        end
        default: begin
          // CTRL_DONE holds until the enable falls
        end
      endcase
      if (!i_cmd_en) begin
        state             <= CTRL_IDLE;
        tx.start          <= 1'b0;
        rx.start          <= 1'b0;
        o_sd_cmd_dir      <= 1'b1;
        o_rsp_finished_en <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sd_cmd_phy.sv
`default_nettype none

module sd_cmd_phy (
  input  logic                    i_sd_clk,
  input  logic                    rst,

  // Host side
  input  logic                    i_cmd_en,
  input  sd_proto_pkg::cmd_word_t i_cmd,
  input  sd_proto_pkg::bit_len_t  i_cmd_len,
  input  sd_proto_pkg::bit_len_t  i_rsp_len,
  output logic                    o_rsp_finished_en,
  output sd_proto_pkg::rsp_word_t o_rsp,
  output logic                    o_crc_err,

  // CMD pad, o_sd_cmd_dir high means the host drives
  output logic                    o_sd_cmd_dir,
  input  logic                    i_sd_cmd,
  output logic                    o_sd_cmd
);

  logic abort;

  sd_cmd_tx_if tx_if ();
  sd_rsp_rx_if rx_if ();

  sd_cmd_ctrl u_ctrl (
    .i_sd_clk          (i_sd_clk),
    .rst               (rst),
    .i_cmd_en          (i_cmd_en),
    .i_cmd             (i_cmd),
    .i_cmd_len         (i_cmd_len),
    .i_rsp_len         (i_rsp_len),
    .tx                (tx_if.ctrl),
    .rx                (rx_if.ctrl),
    .o_abort           (abort),
    .o_sd_cmd_dir      (o_sd_cmd_dir),
    .o_rsp_finished_en (o_rsp_finished_en)
  );

  sd_cmd_tx u_tx (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_abort  (abort),
    .tx       (tx_if.engine),
    .o_sd_cmd (o_sd_cmd)
  );

  sd_rsp_rx u_rx (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_abort  (abort),
    .rx       (rx_if.engine),
    .i_sd_cmd (i_sd_cmd)
  );

  assign o_rsp     = rx_if.rsp;
  assign o_crc_err = rx_if.crc_err;

endmodule

`default_nettype wire

// File: tb_sd_card_model.sv
`default_nettype none

module tb_sd_card_model (
  input  logic                           i_sd_clk,
  input  logic                           i_cmd_en,
  input  logic                           i_sd_cmd_dir,
  input  logic                           i_sd_cmd,
  input  sd_proto_pkg::bit_len_t         i_cmd_len,
  input  sd_proto_pkg::bit_len_t         i_rsp_len,
  input  sd_proto_pkg::rsp_word_t        i_rsp,
  input  sd_proto_pkg::crc7_t            i_rsp_crc,
  input  logic [7:0]                     i_delay,
  output logic                           o_sd_cmd,
  output logic [sd_proto_pkg::CMD_W+7:0] o_frame,
  output logic                           o_frame_valid
);
  import sd_proto_pkg::*;

  logic en_seen;
  logic aborted;

  // Host enable as the DUT sees it, stable at the falling edge
  always @(posedge i_sd_clk) begin
    en_seen <= i_cmd_en;
  end

  task automatic step();
    @(negedge i_sd_clk);
    if (!en_seen) begin
      aborted = 1'b1;
    end
  endtask

  task automatic serve_command();
    logic [CMD_W+7:0] bits;
    int               n;
    aborted       = 1'b0;
    o_frame_valid = 1'b0;
    // Start bit is already on the line
    bits = {{(CMD_W+7){1'b0}}, i_sd_cmd};
    n    = 1;
    while (!aborted && (n < int'(i_cmd_len) + 8)) begin
      step();
      bits = {bits[CMD_W+6:0], i_sd_cmd};
      n++;
    end
    if (!aborted) begin
      o_frame       = bits;
      o_frame_valid = 1'b1;
    end
    // Turnaround, then the response delay
    while (!aborted && i_sd_cmd_dir) begin
      step();
    end
    repeat (i_delay) begin
      if (!aborted) begin
        step();
      end
    end
    // Payload MSB first, its top bit is the zero start bit
    for (int i = int'(i_rsp_len) - 1; (i >= 0) && !aborted; i--) begin
      o_sd_cmd = i_rsp[i];
      step();
    end
    for (int i = CRC7_W - 1; (i >= 0) && !aborted; i--) begin
      o_sd_cmd = i_rsp_crc[i];
      step();
    end
    o_sd_cmd = 1'b1;
  endtask

  initial begin
    o_sd_cmd      = 1'b1;
    o_frame       = '0;
    o_frame_valid = 1'b0;
    aborted       = 1'b0;
    forever begin
      @(negedge i_sd_clk);
      if (en_seen && i_sd_cmd_dir && !i_sd_cmd) begin
        serve_command();
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_sd_cmd_phy.sv
`default_nettype none

module tb_sd_cmd_phy;
  import sd_proto_pkg::*;

  localparam int NUM_TESTS  = 6;
  localparam int SEED       = 37289;
  localparam int RST_CYCLES = 10;
  localparam int FRAME_W    = CMD_W + 8;

  logic               sd_clk = 1'b0;
  logic               rst;
  logic               cmd_en;
  cmd_word_t          cmd;
  bit_len_t           cmd_len;
  bit_len_t           rsp_len;
  logic               rsp_finished_en;
  rsp_word_t          rsp;
  logic               crc_err;
  logic               sd_cmd_dir;
  logic               card_to_host;
  logic               host_to_card;

  // Card settings for the entry in flight
  rsp_word_t          card_rsp;
  crc7_t              card_crc;
  logic [7:0]         card_delay;
  logic [FRAME_W-1:0] frame;
  logic               frame_valid;

  // Stimulus and expected values with one row per test
  string              test_name    [NUM_TESTS];
  cmd_word_t          test_cmd     [NUM_TESTS];
  bit_len_t           test_cmd_len [NUM_TESTS];
  bit_len_t           test_rsp_len [NUM_TESTS];
  rsp_word_t          test_payload [NUM_TESTS];
  logic               test_bad_crc [NUM_TESTS];
  logic [7:0]         test_delay   [NUM_TESTS];
  int                 test_abort   [NUM_TESTS];
  logic [FRAME_W-1:0] test_frame   [NUM_TESTS];

  int                 watchdog_cycles = 0;

  always #2 sd_clk = ~sd_clk;

  sd_cmd_phy u_sd_cmd_phy (
    .i_sd_clk          (sd_clk),
    .rst               (rst),
    .i_cmd_en          (cmd_en),
    .i_cmd             (cmd),
    .i_cmd_len         (cmd_len),
    .i_rsp_len         (rsp_len),
    .o_rsp_finished_en (rsp_finished_en),
    .o_rsp             (rsp),
    .o_crc_err         (crc_err),
    .o_sd_cmd_dir      (sd_cmd_dir),
    .i_sd_cmd          (card_to_host),
    .o_sd_cmd          (host_to_card)
  );

  tb_sd_card_model u_card (
    .i_sd_clk      (sd_clk),
    .i_cmd_en      (cmd_en),
    .i_sd_cmd_dir  (sd_cmd_dir),
    .i_sd_cmd      (host_to_card),
    .i_cmd_len     (cmd_len),
    .i_rsp_len     (rsp_len),
    .i_rsp         (card_rsp),
    .i_rsp_crc     (card_crc),
    .i_delay       (card_delay),
    .o_sd_cmd      (card_to_host),
    .o_frame       (frame),
    .o_frame_valid (frame_valid)
  );

  // MSB-first CRC7 of x^7 + x^3 + 1 over the low len bits
  function automatic crc7_t ref_crc7(input rsp_word_t bits, input int len);
    crc7_t c;
    logic  fb;
    c = '0;
    for (int i = len - 1; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c  = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'b000_1001;
      end
    end
    return c;
  endfunction

  // Top len command bits, their CRC7 and the end bit
  function automatic logic [FRAME_W-1:0] build_frame(input cmd_word_t c, input int len);
    rsp_word_t bits;
    bits = rsp_word_t'(c >> (CMD_W - len));
    return {bits[CMD_W-1:0], ref_crc7(bits, len), 1'b1};
  endfunction

  function automatic cmd_word_t random_command();
    logic [63:0] r;
    r = {$urandom, $urandom};
    // Start bit 0 and transmission bit 1
    return {2'b01, r[CMD_W-3:0]};
  endfunction

  function automatic rsp_word_t random_response(input int len);
    logic [159:0] r;
    rsp_word_t    w;
    r = {$urandom, $urandom, $urandom, $urandom, $urandom};
    w = r[RSP_W-1:0] & ((rsp_word_t'(1) << len) - 1'b1);
    w[len-1] = 1'b0;
    return w;
  endfunction

  task automatic check_value(input string name, input rsp_word_t expected,
                             input rsp_word_t actual);
    if (expected !== actual) begin
      $display("Error %s expected %h actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic add_entry(input int idx, input string name, input bit_len_t clen,
                           input bit_len_t rlen, input logic bad, input logic [7:0] delay,
                           input int abort_after);
    test_name[idx]    = name;
    test_cmd[idx]     = random_command();
    test_cmd_len[idx] = clen;
    test_rsp_len[idx] = rlen;
    test_payload[idx] = random_response(int'(rlen));
    test_bad_crc[idx] = bad;
    test_delay[idx]   = delay;
    test_abort[idx]   = abort_after;
    test_frame[idx]   = build_frame(test_cmd[idx], int'(clen));
  endtask

  task automatic run_entry(input int idx);
    string n;
    n = test_name[idx];
    @(negedge sd_clk);
    cmd        = test_cmd[idx];
    cmd_len    = test_cmd_len[idx];
    rsp_len    = test_rsp_len[idx];
    card_rsp   = test_payload[idx];
    card_crc   = ref_crc7(test_payload[idx], int'(test_rsp_len[idx])) ^
                 (test_bad_crc[idx] ? 7'h7f : 7'h00);
    card_delay = test_delay[idx];
    cmd_en     = 1'b1;
    if (test_abort[idx] != 0) begin
      repeat (test_abort[idx]) @(negedge sd_clk);
      cmd_en = 1'b0;
      @(negedge sd_clk);
      check_value({n, ".dir"}, 1, sd_cmd_dir);
      check_value({n, ".cmd_line"}, 1, host_to_card);
      check_value({n, ".finished"}, 0, rsp_finished_en);
      repeat (3) @(negedge sd_clk);
      check_value({n, ".cmd_line_idle"}, 1, host_to_card);
      check_value({n, ".finished_idle"}, 0, rsp_finished_en);
    end
    else begin
      while (sd_cmd_dir) @(negedge sd_clk);
      check_value({n, ".frame_valid"}, 1, frame_valid);
      check_value({n, ".frame"}, test_frame[idx], frame);
      while (!rsp_finished_en) @(negedge sd_clk);
      if (test_rsp_len[idx] < RSP_W) begin
        check_value({n, ".rsp_upper"}, 0, rsp >> test_rsp_len[idx]);
      end
      check_value({n, ".rsp"}, test_payload[idx], rsp);
      check_value({n, ".crc_err"}, test_bad_crc[idx], crc_err);
      check_value({n, ".dir_back"}, 1, sd_cmd_dir);
      cmd_en = 1'b0;
      @(negedge sd_clk);
      check_value({n, ".finished_clear"}, 0, rsp_finished_en);
      repeat (2) @(negedge sd_clk);
    end
  endtask

  // Ends a hung run
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge sd_clk);
    $display("Timeout, the run did not finish within %0d cycles", watchdog_cycles);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int seed_ack;
    int budget;
    seed_ack   = $urandom(SEED);
    rst        = 1'b1;
    cmd_en     = 1'b0;
    cmd        = '0;
    cmd_len    = '0;
    rsp_len    = '0;
    card_rsp   = '0;
    card_crc   = '0;
    card_delay = '0;

    add_entry(0, "full_r2", 40, 136, 1'b0, 8'd2, 0);
    add_entry(1, "short_r1", 40, 48, 1'b0, 8'(2 + $urandom % 8), 0);
    add_entry(2, "bad_crc", 40, 48, 1'b1, 8'd3, 0);
    add_entry(3, "good_after_bad", 40, 48, 1'b0, 8'(2 + $urandom % 8), 0);
    add_entry(4, "abort_in_cmd", 40, 48, 1'b0, 8'd2, 12);
    add_entry(5, "after_abort", 32, 48, 1'b0, 8'd4, 0);

    budget = RST_CYCLES;
    for (int i = 0; i < NUM_TESTS; i++) begin
      budget += int'(test_cmd_len[i]) + int'(test_rsp_len[i]) + int'(test_delay[i]) + 40;
    end
    watchdog_cycles = budget;

    // Known CMD0 frame CRC from the SD specification
    check_value("crc7_reference", 7'h4a, ref_crc7(rsp_word_t'(40'h40_0000_0000), 40));

    repeat (RST_CYCLES) @(negedge sd_clk);
    rst = 1'b0;
    @(negedge sd_clk);
    check_value("reset.cmd_line", 1, host_to_card);
    check_value("reset.dir", 1, sd_cmd_dir);
    check_value("reset.finished", 0, rsp_finished_en);
    check_value("reset.crc_err", 0, crc_err);
    check_value("reset.rsp", 0, rsp);

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sd_cmd_phy.f
sd_proto_pkg.sv
sd_cmd_state_pkg.sv
sd_cmd_tx_if.sv
sd_rsp_rx_if.sv
sd_crc7.sv
sd_cmd_tx.sv
sd_rsp_rx.sv
sd_cmd_ctrl.sv
sd_cmd_phy.sv
tb_sd_card_model.sv
tb_sd_cmd_phy.sv
